//--- include/imuldiv_tb_vectors.svh
// ----------------------------------------
// imuldiv test vectors
// operands, opcode and expected 64-bit result
// ----------------------------------------

`ifndef IMULDIV_TB_VECTORS_SVH
`define IMULDIV_TB_VECTORS_SVH

localparam int NUM_VECTORS = 28;

// one entry per index: name, opcode, a, b, expected result
string               vec_name [NUM_VECTORS];
imuldiv_fn_e         vec_fn   [NUM_VECTORS];
logic [XLEN-1:0]     vec_a    [NUM_VECTORS];
logic [XLEN-1:0]     vec_b    [NUM_VECTORS];
logic [RESULT_W-1:0] vec_exp  [NUM_VECTORS];
int                  vec_count = 0;

task automatic add_vector(input string name, input imuldiv_fn_e fn, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input logic [RESULT_W-1:0] exp);
  vec_name[vec_count] = name;
  vec_fn[vec_count]   = fn;
  vec_a[vec_count]    = a;
  vec_b[vec_count]    = b;
  vec_exp[vec_count]  = exp;
  vec_count++;
endtask

task automatic load_vectors();
  // unsigned divide, result is {a mod b, a div b}
  add_vector("divu_basic",   FN_DIVU, 32'h0000_0064, 32'h0000_0007, 64'h0000_0002_0000_000E);
  add_vector("divu_b_gt_a",  FN_DIVU, 32'h0000_0005, 32'h0000_0009, 64'h0000_0005_0000_0000);
  add_vector("divu_big",     FN_DIVU, 32'hFFFF_FFFF, 32'h0000_0010, 64'h0000_000F_0FFF_FFFF);
  add_vector("divu_msb_gt",  FN_DIVU, 32'h8000_0000, 32'h8000_0001, 64'h8000_0000_0000_0000);
  add_vector("divu_msb_div", FN_DIVU, 32'hFFFF_FFFF, 32'h8000_0000, 64'h7FFF_FFFF_0000_0001);
  add_vector("divu_by_one",  FN_DIVU, 32'hDEAD_BEEF, 32'h0000_0001, 64'h0000_0000_DEAD_BEEF);
  add_vector("divu_exact",   FN_DIVU, 32'h0001_0000, 32'h0000_0100, 64'h0000_0000_0000_0100);
  // signed divide truncates toward zero, remainder follows the dividend
  add_vector("div_pos_pos",  FN_DIV,  32'h0000_0064, 32'h0000_0007, 64'h0000_0002_0000_000E);
  add_vector("div_neg_pos",  FN_DIV,  32'hFFFF_FF9C, 32'h0000_0007, 64'hFFFF_FFFE_FFFF_FFF2);
  add_vector("div_pos_neg",  FN_DIV,  32'h0000_0064, 32'hFFFF_FFF9, 64'h0000_0002_FFFF_FFF2);
  add_vector("div_neg_neg",  FN_DIV,  32'hFFFF_FF9C, 32'hFFFF_FFF9, 64'hFFFF_FFFE_0000_000E);
  add_vector("div_min_neg1", FN_DIV,  32'h8000_0000, 32'hFFFF_FFFF, 64'h0000_0000_8000_0000);
  add_vector("div_small",    FN_DIV,  32'h0000_0003, 32'hFFFF_FFF6, 64'h0000_0003_0000_0000);
  add_vector("div_neg_sm",   FN_DIV,  32'hFFFF_FFFD, 32'h0000_000A, 64'hFFFF_FFFD_0000_0000);
  add_vector("div_min_by_2", FN_DIV,  32'h8000_0000, 32'h0000_0002, 64'h0000_0000_C000_0000);
  // unsigned multiply, full 64-bit product
  add_vector("mulu_zero",    FN_MULU, 32'h0000_0000, 32'h1234_5678, 64'h0000_0000_0000_0000);
  add_vector("mulu_one",     FN_MULU, 32'h0000_0001, 32'hDEAD_BEEF, 64'h0000_0000_DEAD_BEEF);
  add_vector("mulu_ones",    FN_MULU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'hFFFF_FFFE_0000_0001);
  add_vector("mulu_carry",   FN_MULU, 32'h0001_0000, 32'h0001_0000, 64'h0000_0001_0000_0000);
  add_vector("mulu_msb",     FN_MULU, 32'h8000_0000, 32'h0000_0003, 64'h0000_0001_8000_0000);
  // signed multiply, two's complement product
  add_vector("mul_pos_pos",  FN_MUL,  32'h0000_0007, 32'h0000_0006, 64'h0000_0000_0000_002A);
  add_vector("mul_neg_pos",  FN_MUL,  32'hFFFF_FFF9, 32'h0000_0006, 64'hFFFF_FFFF_FFFF_FFD6);
  add_vector("mul_neg_neg",  FN_MUL,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'h0000_0000_0000_0001);
  add_vector("mul_ones_one", FN_MUL,  32'hFFFF_FFFF, 32'h0000_0001, 64'hFFFF_FFFF_FFFF_FFFF);
  add_vector("mul_min_min",  FN_MUL,  32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000);
  add_vector("mul_min_neg1", FN_MUL,  32'h8000_0000, 32'hFFFF_FFFF, 64'h0000_0000_8000_0000);
  add_vector("mul_zero_neg", FN_MUL,  32'h0000_0000, 32'hFFFF_FFFB, 64'h0000_0000_0000_0000);
  add_vector("mul_mixed",    FN_MUL,  32'h1234_5678, 32'hFFFF_FFFE, 64'hFFFF_FFFF_DB97_5310);
endtask

`endif

//--- dv/imuldiv_tb.sv
// ----------------------------------------
// imuldiv testbench
// table-driven checks under random back-pressure
// ----------------------------------------

`timescale 1ns/1ps

module imuldiv_tb import imuldiv_pkg::*; ();

  localparam int          CLK_PERIOD        = 4;
  localparam int          RESET_CYCLES      = 10;
  // budget per vector well above 33 cycles plus back-pressure
  localparam int          CYCLES_PER_VECTOR = 100;
  localparam logic [31:0] SEED              = 32'heb1f_c13a;

  logic                clk;
  logic                reset;
  imuldiv_fn_e         req_fn;
  logic [XLEN-1:0]     req_a;
  logic [XLEN-1:0]     req_b;
  logic                req_val;
  logic                req_rdy;
  logic [RESULT_W-1:0] resp_result;
  logic                resp_val;
  logic                resp_rdy;

  `include "imuldiv_tb_vectors.svh"

  imuldiv_top uut (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ----------------------------------------
  // error handling and compares
  // ----------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_result(input string name, input logic [RESULT_W-1:0] expected,
                              input logic [RESULT_W-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
    end
  endtask

  // ----------------------------------------
  // one table entry through the handshake
  // ----------------------------------------

  task automatic run_vector(input int idx);
    logic seen;
    logic done;
    // called on a falling edge and holds the request until it transfers
    req_fn  = vec_fn[idx];
    req_a   = vec_a[idx];
    req_b   = vec_b[idx];
    req_val = 1'b1;
    while (req_rdy !== 1'b1) begin
      @(negedge clk);
    end
    // the rising edge in between accepted the request
    @(negedge clk);
    req_val = 1'b0;
    // scramble the idle request since the unit has captured its operands
    req_a   = $urandom;
    req_b   = $urandom;
    seen    = 1'b0;
    done    = 1'b0;
    while (!done) begin
      if (resp_val === 1'b1) begin
        if (!seen) begin
          check_result(vec_name[idx], vec_exp[idx], resp_result);
          seen = 1'b1;
        end else begin
          // result stays put while the response waits
          check_result({vec_name[idx], " held"}, vec_exp[idx], resp_result);
        end
      end else begin
        compare_flag({vec_name[idx], " req_rdy busy"}, 1'b0, req_rdy);
      end
      resp_rdy = ($urandom % 2) != 0;
      // transfer happens on the next rising edge
      done = (resp_val === 1'b1) && resp_rdy;
      @(negedge clk);
    end
    // exactly one response and the unit back in idle
    compare_flag({vec_name[idx], " resp_val after"}, 1'b0, resp_val);
    compare_flag({vec_name[idx], " req_rdy after"}, 1'b1, req_rdy);
  endtask

  // ----------------------------------------
  // monitors
  // ----------------------------------------

  // a unit holding a response must never look ready for a new request
  always @(negedge clk) begin
    if (req_rdy && resp_val) begin
      abort_run("req_rdy and resp_val were both high in the same cycle");
    end
  end

  // watchdog sized from the table length
  initial begin
    repeat (RESET_CYCLES + NUM_VECTORS * CYCLES_PER_VECTOR) @(posedge clk);
    abort_run("timeout: the test did not finish in the allowed number of cycles");
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    void'($urandom(SEED));
    reset    = 1'b1;
    req_fn   = FN_MUL;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    load_vectors();
    if (vec_count != NUM_VECTORS) begin
      abort_run("vector table does not match its declared size");
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    compare_flag("reset req_rdy", 1'b1, req_rdy);
    compare_flag("reset resp_val", 1'b0, resp_val);
    for (int i = 0; i < NUM_VECTORS; i++) begin
      run_vector(i);
    end
    $display("%0d vectors applied", NUM_VECTORS);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- source/imuldiv_div_ctrl.sv
// ----------------------------------------
// imuldiv divider control
// idle/calc/done FSM driving the datapath
// ----------------------------------------

`timescale 1ns/1ps

module imuldiv_div_ctrl import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,

  // request side
  input  imuldiv_fn_e req_fn,
  input  logic        req_val,
  output logic        req_rdy,

  // response side
  input  logic        resp_rdy,
  output logic        resp_val,

  // status from the datapath
  input  logic        sub_msb,
  input  logic        counter_is_zero,

  // datapath controls
  output logic        is_signed,
  output logic        a_en,
  output logic        b_en,
  output logic        a_mux_sel,
  output logic        sub_mux_sel,
  output logic        cntr_mux_sel,
  output logic        sign_en,
  output logic        rem_sign_mux_sel,
  output logic        div_sign_mux_sel
);

  unit_state_e state;
  unit_state_e state_next;

  // signedness held for the whole operation
  logic signed_reg;
  logic accept;

  assign accept = (state == ST_IDLE) && req_val;

  // live decode while idle so the load sees it on the accepting edge
  assign is_signed = (state == ST_IDLE) ? (req_fn == FN_DIV) : signed_reg;

  // ----------------------------------------
  // state register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_IDLE;
      signed_reg <= 1'b0;
    end else begin
      state <= state_next;
      if (accept) begin
        signed_reg <= (req_fn == FN_DIV);
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: if (accept) state_next = ST_CALC;
      // last iteration runs on the edge that leaves calc
      ST_CALC: if (counter_is_zero) state_next = ST_DONE;
      ST_DONE: if (resp_rdy) state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------

  always_comb begin
    req_rdy          = 1'b0;
    resp_val         = 1'b0;
    a_en             = 1'b0;
    b_en             = 1'b0;
    a_mux_sel        = 1'b0;
    sub_mux_sel      = 1'b0;
    cntr_mux_sel     = 1'b0;
    sign_en          = 1'b0;
    rem_sign_mux_sel = 1'b0;
    div_sign_mux_sel = 1'b0;
    case (state)
      ST_IDLE: begin
        // load operands and signs on acceptance, counter reloads
        req_rdy = 1'b1;
        a_en    = accept;
        b_en    = accept;
        sign_en = accept;
      end
      ST_CALC: begin
        // one shift-subtract per cycle
        a_en         = 1'b1;
        a_mux_sel    = 1'b1;
        sub_mux_sel  = sub_msb;
        cntr_mux_sel = 1'b1;
      end
      ST_DONE: begin
        resp_val         = 1'b1;
        rem_sign_mux_sel = signed_reg;
        div_sign_mux_sel = signed_reg;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

//--- source/imuldiv_div_dpath.sv
// ----------------------------------------
// imuldiv divider datapath
// restoring shift-subtract with sign fixup
// ----------------------------------------

`timescale 1ns/1ps

module imuldiv_div_dpath import imuldiv_pkg::*; (
  input  logic                clk,
  input  logic                reset,

  // operands from the request port
  input  logic [XLEN-1:0]     req_a,
  input  logic [XLEN-1:0]     req_b,

  // controls from the divider FSM
  input  logic                a_en,
  input  logic                b_en,
  input  logic                a_mux_sel,
  input  logic                sub_mux_sel,
  input  logic                cntr_mux_sel,
  input  logic                sign_en,
  input  logic                is_signed,
  input  logic                rem_sign_mux_sel,
  input  logic                div_sign_mux_sel,

  // status back to the FSM
  output logic                sub_msb,
  output logic                counter_is_zero,

  // {remainder, quotient}
  output logic [RESULT_W-1:0] result
);

  // remainder/quotient register, one guard bit above the remainder
  logic [RESULT_W:0]   a_reg;
  // divisor aligned to the upper half
  logic [RESULT_W:0]   b_reg;
  logic [ITER_W-1:0]   counter_reg;
  // captured result signs
  logic                div_sign_reg;
  logic                rem_sign_reg;

  logic [XLEN-1:0]     a_norm;
  logic [XLEN-1:0]     b_norm;
  logic [RESULT_W:0]   a_init;
  logic [RESULT_W:0]   b_init;
  logic [RESULT_W:0]   a_shift;
  logic [RESULT_W:0]   sub_out;
  logic [RESULT_W:0]   sub_mux_out;
  logic [RESULT_W:0]   a_mux_out;
  logic [ITER_W-1:0]   counter_next;
  logic [XLEN-1:0]     quotient;
  logic [XLEN-1:0]     remainder;

  // ----------------------------------------
  // operand load
  // ----------------------------------------

  // magnitudes only for the signed opcode
  assign a_norm = (is_signed && req_a[XLEN-1]) ? (~req_a + 1'b1) : req_a;
  assign b_norm = (is_signed && req_b[XLEN-1]) ? (~req_b + 1'b1) : req_b;

  // dividend in the low half, divisor shifted up by XLEN
  assign a_init = {{(XLEN+1){1'b0}}, a_norm};
  assign b_init = {1'b0, b_norm, {XLEN{1'b0}}};

  // ----------------------------------------
  // shift and subtract
  // ----------------------------------------

  assign a_shift = a_reg << 1;
  assign sub_out = a_shift - b_reg;

  // a negative difference means the divisor did not fit
  assign sub_msb = sub_out[RESULT_W];

  // restore keeps the shifted value with a zero quotient bit,
  // otherwise take the difference and set the quotient bit
  assign sub_mux_out = sub_mux_sel ? {a_shift[RESULT_W:1], 1'b0}
                                   : {sub_out[RESULT_W:1], 1'b1};

  assign a_mux_out = a_mux_sel ? sub_mux_out : a_init;

  // ----------------------------------------
  // iteration counter
  // ----------------------------------------

  // reload 31 while idle, count down during calc
  assign counter_next    = cntr_mux_sel ? (counter_reg - 1'b1) : ITER_W'(XLEN - 1);
  assign counter_is_zero = (counter_reg == '0);

  // ----------------------------------------
  // registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_init;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg  <= ITER_W'(XLEN - 1);
      div_sign_reg <= 1'b0;
      rem_sign_reg <= 1'b0;
    end else begin
      counter_reg <= counter_next;
      // quotient negative when signs differ, remainder follows the dividend
      if (sign_en) begin
        div_sign_reg <= is_signed & (req_a[XLEN-1] ^ req_b[XLEN-1]);
        rem_sign_reg <= is_signed & req_a[XLEN-1];
      end
    end
  end

  // ----------------------------------------
  // sign fixup
  // ----------------------------------------

  assign quotient  = a_reg[XLEN-1:0];
  assign remainder = a_reg[RESULT_W-1:XLEN];

  // selects from control only open the negation in done
  assign result[XLEN-1:0] = (div_sign_mux_sel && div_sign_reg) ? (~quotient + 1'b1)
                                                               : quotient;
  assign result[RESULT_W-1:XLEN] = (rem_sign_mux_sel && rem_sign_reg) ? (~remainder + 1'b1)
                                                                      : remainder;

endmodule

//--- source/imuldiv_mul_iterative.sv
// ----------------------------------------
// imuldiv iterative multiplier
// shift-and-add over 32 cycles, 64-bit product
// ----------------------------------------

`timescale 1ns/1ps

module imuldiv_mul_iterative import imuldiv_pkg::*; (
  input  logic                clk,
  input  logic                reset,

  // request side
  input  imuldiv_fn_e         req_fn,
  input  logic [XLEN-1:0]     req_a,
  input  logic [XLEN-1:0]     req_b,
  input  logic                req_val,
  output logic                req_rdy,

  // response side
  input  logic                resp_rdy,
  output logic                resp_val,
  output logic [RESULT_W-1:0] result
);

  unit_state_e state;
  unit_state_e state_next;

  // multiplicand widened so it can shift up into the high half
  logic [RESULT_W-1:0] a_reg;
  // multiplier, consumed from the lsb
  logic [XLEN-1:0]     b_reg;
  logic [RESULT_W-1:0] acc_reg;
  logic [ITER_W-1:0]   counter_reg;
  // product sign
  logic                neg_reg;

  logic                is_signed;
  logic                accept;
  logic [XLEN-1:0]     a_mag;
  logic [XLEN-1:0]     b_mag;

  assign is_signed = (req_fn == FN_MUL);
  assign accept    = (state == ST_IDLE) && req_val;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  assign a_mag = (is_signed && req_a[XLEN-1]) ? (~req_a + 1'b1) : req_a;
  assign b_mag = (is_signed && req_b[XLEN-1]) ? (~req_b + 1'b1) : req_b;

  // ----------------------------------------
  // FSM, same timing as the divider
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ST_IDLE;
      counter_reg <= ITER_W'(XLEN - 1);
      neg_reg     <= 1'b0;
    end else begin
      state <= state_next;
      if (accept) begin
        counter_reg <= ITER_W'(XLEN - 1);
        neg_reg     <= is_signed & (req_a[XLEN-1] ^ req_b[XLEN-1]);
      end else if (state == ST_CALC) begin
        counter_reg <= counter_reg - 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: if (accept) state_next = ST_CALC;
      ST_CALC: if (counter_reg == '0) state_next = ST_DONE;
      ST_DONE: if (resp_rdy) state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);

  // ----------------------------------------
  // shift-and-add datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      a_reg   <= {{XLEN{1'b0}}, a_mag};
      b_reg   <= b_mag;
      acc_reg <= '0;
    end else if (state == ST_CALC) begin
      // add the aligned multiplicand for each set multiplier bit
      if (b_reg[0]) begin
        acc_reg <= acc_reg + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // negate the magnitude product when the signs differed
  assign result = neg_reg ? (~acc_reg + 1'b1) : acc_reg;

endmodule

//--- source/imuldiv_pkg.sv
// ----------------------------------------
// imuldiv shared definitions
// opcodes, unit states and datapath widths
// ----------------------------------------

package imuldiv_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  // operand width
  localparam int XLEN = 32;

  // full result width, product or {remainder, quotient}
  localparam int RESULT_W = 64;

  // iteration counter, loaded with 31 for 32 iterations
  localparam int ITER_W = 5;

  // ----------------------------------------
  // function opcode
  // ----------------------------------------

  // signed and unsigned variants of each operation
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_MULU = 2'd1,
    FN_DIV  = 2'd2,
    FN_DIVU = 2'd3
  } imuldiv_fn_e;

  // ----------------------------------------
  // unit state
  // ----------------------------------------

  // shared by the divider control and the multiplier
  // idle accepts, calc iterates, done holds the response
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } unit_state_e;

endpackage

//--- source/imuldiv_top.sv
// ----------------------------------------
// imuldiv top level
// steers requests and muxes responses
// ----------------------------------------

`timescale 1ns/1ps

module imuldiv_top import imuldiv_pkg::*; (
  input  logic                clk,
  input  logic                reset,

  // request port
  input  imuldiv_fn_e         req_fn,
  input  logic [XLEN-1:0]     req_a,
  input  logic [XLEN-1:0]     req_b,
  input  logic                req_val,
  output logic                req_rdy,

  // response port
  output logic [RESULT_W-1:0] resp_result,
  output logic                resp_val,
  input  logic                resp_rdy
);

  logic                is_div;
  logic                div_req_val;
  logic                div_req_rdy;
  logic                div_resp_val;
  logic [RESULT_W-1:0] div_result;
  logic                mul_req_val;
  logic                mul_req_rdy;
  logic                mul_resp_val;
  logic [RESULT_W-1:0] mul_result;

  // divider control to datapath
  logic                a_en;
  logic                b_en;
  logic                a_mux_sel;
  logic                sub_mux_sel;
  logic                cntr_mux_sel;
  logic                sign_en;
  logic                is_signed;
  logic                rem_sign_mux_sel;
  logic                div_sign_mux_sel;
  logic                sub_msb;
  logic                counter_is_zero;

  // ----------------------------------------
  // request steering
  // ----------------------------------------

  assign is_div = (req_fn == FN_DIV) || (req_fn == FN_DIVU);

  // one operation in flight, so accept only with both units idle
  assign req_rdy     = div_req_rdy & mul_req_rdy;
  assign div_req_val = req_val & req_rdy & is_div;
  assign mul_req_val = req_val & req_rdy & ~is_div;

  // response from whichever unit holds one
  assign resp_val    = div_resp_val | mul_resp_val;
  assign resp_result = div_resp_val ? div_result : mul_result;

  imuldiv_div_ctrl div_ctrl (
    .clk              (clk),
    .reset            (reset),
    .req_fn           (req_fn),
    .req_val          (div_req_val),
    .req_rdy          (div_req_rdy),
    .resp_rdy         (resp_rdy),
    .resp_val         (div_resp_val),
    .sub_msb          (sub_msb),
    .counter_is_zero  (counter_is_zero),
    .is_signed        (is_signed),
    .a_en             (a_en),
    .b_en             (b_en),
    .a_mux_sel        (a_mux_sel),
    .sub_mux_sel      (sub_mux_sel),
    .cntr_mux_sel     (cntr_mux_sel),
    .sign_en          (sign_en),
    .rem_sign_mux_sel (rem_sign_mux_sel),
    .div_sign_mux_sel (div_sign_mux_sel)
  );

  imuldiv_div_dpath div_dpath (
    .clk              (clk),
    .reset            (reset),
    .req_a            (req_a),
    .req_b            (req_b),
    .a_en             (a_en),
    .b_en             (b_en),
    .a_mux_sel        (a_mux_sel),
    .sub_mux_sel      (sub_mux_sel),
    .cntr_mux_sel     (cntr_mux_sel),
    .sign_en          (sign_en),
    .is_signed        (is_signed),
    .rem_sign_mux_sel (rem_sign_mux_sel),
    .div_sign_mux_sel (div_sign_mux_sel),
    .sub_msb          (sub_msb),
    .counter_is_zero  (counter_is_zero),
    .result           (div_result)
  );

  imuldiv_mul_iterative mul (
    .clk      (clk),
    .reset    (reset),
    .req_fn   (req_fn),
    .req_a    (req_a),
    .req_b    (req_b),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_rdy (resp_rdy),
    .resp_val (mul_resp_val),
    .result   (mul_result)
  );

endmodule

//--- vlog.f
+incdir+include
source/imuldiv_pkg.sv
source/imuldiv_div_dpath.sv
source/imuldiv_div_ctrl.sv
source/imuldiv_mul_iterative.sv
source/imuldiv_top.sv
dv/imuldiv_tb.sv
